// ==== Bender.yml ====
package:
  name: rv32i_single_cycle

sources:
  - files:
      - hw/rv_pkg.sv
      - hw/alu.sv
      - hw/control_unit.sv
      - hw/immediate_generator.sv
      - hw/register_file.sv
      - hw/pc_counter.sv
      - hw/data_memory.sv
      - hw/cpu.sv
  - target: test
    files:
      - dv/cpu_checker.sv
      - dv/tb_cpu.sv

// ==== dv/cpu_checker.sv ====
////////////////////////////////////////////////////////////
// Protocol assertions bound into the core top level
// fail_count is read by the testbench at the end of the run
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cpu_checker #(
    parameter int PC_WIDTH = 16
) (
    input logic                sysclk,
    input logic                arst_n,
    input logic [PC_WIDTH-1:0] imem_addr,
    input logic                rd_we,
    input logic [4:0]          rd_addr,
    input logic                st_en,
    input logic [31:0]         st_addr
);

    int fail_count = 0;

    a_reset_pc: assert property (@(posedge sysclk) !arst_n |-> imem_addr == '0)
        else begin $error("PC not zero during reset"); fail_count++; end

    a_no_x0_write: assert property (@(posedge sysclk) disable iff (!arst_n)
        rd_we |-> rd_addr != 5'd0)
        else begin $error("Register write strobe with x0 as destination"); fail_count++; end

    // Whole-word stores only
    a_store_aligned: assert property (@(posedge sysclk) disable iff (!arst_n)
        st_en |-> st_addr[1:0] == 2'b00)
        else begin $error("Store address not word aligned"); fail_count++; end

endmodule

// ==== dv/tb_cpu.sv ====
////////////////////////////////////////////////////////////
// Testbench for the single-cycle RV32I core
// Program memory lives here and answers fetches combinationally.
// Random programs only branch forward and end in a self-jump
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_cpu;

    localparam int PC_WIDTH        = 16;
    localparam int DMEM_ADDR_WIDTH = 10;
    localparam int N_INSTR         = 256;
    localparam int CLK_PERIOD      = 10;
    localparam int STIM_DELAY      = 1;
    localparam int WATCHDOG_NS     = (N_INSTR + 20) * CLK_PERIOD;

    localparam logic [6:0] OP_REG    = 7'h33;
    localparam logic [6:0] OP_IMM    = 7'h13;
    localparam logic [6:0] OP_LOAD   = 7'h03;
    localparam logic [6:0] OP_STORE  = 7'h23;
    localparam logic [6:0] OP_BRANCH = 7'h63;
    localparam logic [6:0] OP_JAL    = 7'h6f;
    localparam logic [6:0] OP_JALR   = 7'h67;
    localparam logic [6:0] OP_LUI    = 7'h37;
    localparam logic [6:0] OP_AUIPC  = 7'h17;

    localparam int T_RESET = 0;
    localparam int T_ALU   = 1;
    localparam int T_UPPER = 2;
    localparam int T_MEM   = 3;
    localparam int T_FLOW  = 4;
    localparam int T_X0    = 5;
    localparam int T_BIND  = 6;
    localparam int NTESTS  = 7;

    logic                sysclk;
    logic                arst_n;
    logic [31:0]         imem_rdata;
    logic [PC_WIDTH-1:0] imem_addr;
    logic                rd_we;
    logic [4:0]          rd_addr;
    logic [31:0]         rd_data;
    logic                st_en;
    logic [31:0]         st_addr;
    logic [31:0]         st_data;
    logic                pc_taken;

    logic [31:0] prog [0:N_INSTR-1];
    logic [31:0] m_regs [0:31];
    logic [31:0] m_mem [0:(1<<DMEM_ADDR_WIDTH)-1];
    logic [31:0] m_pc;
    logic [31:0] m_ins;
    logic [4:0]  m_rd;
    logic [31:0] rng_state;
    logic        exp_writes;
    logic        exp_we;
    logic        exp_st;
    logic        exp_taken;
    logic [31:0] exp_val;
    logic [31:0] exp_st_addr;
    logic [31:0] exp_st_data;
    logic [31:0] exp_next;
    int          cat;
    int          rd_cat;
    int          cycle;
    logic        done;
    int          total_checks;
    int          total_errs;
    int          checks [NTESTS];
    int          errs [NTESTS];
    string       names [NTESTS] = '{"reset", "alu", "upper", "memory", "flow", "x0", "bind"};

    cpu #(.PC_WIDTH(PC_WIDTH), .DMEM_ADDR_WIDTH(DMEM_ADDR_WIDTH)) UUT (
        .sysclk(sysclk), .arst_n(arst_n), .imem_rdata(imem_rdata), .imem_addr(imem_addr),
        .rd_we(rd_we), .rd_addr(rd_addr), .rd_data(rd_data), .st_en(st_en),
        .st_addr(st_addr), .st_data(st_data), .pc_taken(pc_taken)
    );

    bind cpu cpu_checker #(.PC_WIDTH(PC_WIDTH)) bound_checks (
        .sysclk(sysclk), .arst_n(arst_n), .imem_addr(imem_addr), .rd_we(rd_we),
        .rd_addr(rd_addr), .st_en(st_en), .st_addr(st_addr)
    );

    // Fetch returns zero while the core is held in reset
    assign imem_rdata = arst_n ? prog[imem_addr[PC_WIDTH-1:2]] : 32'h0;

    initial begin
        sysclk = 1'b0;
        forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the program never reached its final self-jump");
        $display("tests failed");
        $finish;
    end

    function automatic logic [31:0] rand_next();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // Integer result as RV32I defines it for funct3 and instruction bit 30
    function automatic logic [31:0] alu_model(logic [2:0] f3, logic alt, logic [31:0] a,
                                              logic [31:0] b);
        logic [31:0] res;
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'b0, $signed(a) < $signed(b)};
            3'd3: res = {31'b0, a < b};
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt) res = $signed(a) >>> b[4:0];
                else     res = a >> b[4:0];
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic logic branch_model(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Program generation
    ////////////////////////////////////////////////////////////
    task automatic gen_program();
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        int          k;
        prog[0] = 32'h0;                            // NOP keeps the first cycle quiet
        prog[1] = {20'h00001, 5'd1, OP_LUI};        // x1 is the load/store base
        prog[2] = {12'h100, 5'd1, 3'b000, 5'd1, OP_IMM};
        for (int s = 0; s < 16; s++) begin
            prog[3 + s] = enc_s(12'(4 * s), 5'd0, 5'd1);   // Every data slot gets defined
        end
        for (int i = 19; i < N_INSTR - 1; i++) begin
            r   = rand_next();
            r2  = rand_next();
            rd  = (r[8:4] == 5'd1) ? 5'd2 : r[8:4];
            rs1 = r[13:9];
            rs2 = r[18:14];
            f3  = r[21:19];
            k   = 1 + int'(r2[1:0]);
            if (i + k > N_INSTR - 1) k = N_INSTR - 1 - i;
            case (r[3:0])
                4'd0, 4'd1, 4'd2, 4'd3, 4'd4:
                    prog[i] = {(r[22] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                               rs2, rs1, f3, rd, OP_REG};
                4'd5, 4'd6, 4'd7, 4'd8: begin
                    if (f3 == 3'd1)      imm = {7'h00, r2[4:0]};
                    else if (f3 == 3'd5) imm = {r[22] ? 7'h20 : 7'h00, r2[4:0]};
                    else                 imm = r2[11:0];
                    prog[i] = {imm, rs1, f3, rd, OP_IMM};
                end
                4'd9:  prog[i] = {r2[31:12], rd, OP_LUI};
                4'd10: prog[i] = {r2[31:12], rd, OP_AUIPC};
                4'd11: prog[i] = enc_s({6'b0, r2[5:2], 2'b0}, rs2, 5'd1);
                4'd12: prog[i] = {6'b0, r2[5:2], 2'b0, 5'd1, 3'b010, rd, OP_LOAD};
                4'd13: prog[i] = enc_b(13'(4 * k), rs2, rs1,
                                       (f3 == 3'd2 || f3 == 3'd3) ? 3'd0 : f3);
                4'd14: prog[i] = enc_j(21'(4 * k), rd);
                // Absolute target with bit 0 set, which JALR must drop
                default: prog[i] = {12'(4 * (i + k) + 1), 5'd0, 3'b000, rd, OP_JALR};
            endcase
        end
        prog[N_INSTR-1] = enc_j(21'd0, 5'd0);
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    task automatic predict();
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] addr;
        m_ins = prog[m_pc[PC_WIDTH-1:2]];
        opc   = m_ins[6:0];
        f3    = m_ins[14:12];
        m_rd  = m_ins[11:7];
        a     = m_regs[m_ins[19:15]];
        b     = m_regs[m_ins[24:20]];
        imm_i = {{20{m_ins[31]}}, m_ins[31:20]};
        exp_writes  = 1'b0;
        exp_val     = '0;
        exp_st      = 1'b0;
        exp_st_addr = '0;
        exp_st_data = '0;
        exp_taken   = 1'b0;
        exp_next    = m_pc + 4;
        cat         = T_FLOW;
        case (opc)
            OP_REG: begin
                cat = T_ALU;
                exp_writes = 1'b1;
                exp_val = alu_model(f3, m_ins[30], a, b);
            end
            OP_IMM: begin
                cat = T_ALU;
                exp_writes = 1'b1;
                exp_val = alu_model(f3, m_ins[30] && f3 == 3'd5, a, imm_i);
            end
            OP_LOAD: begin
                cat = T_MEM;
                exp_writes = 1'b1;
                addr = a + imm_i;
                exp_val = m_mem[addr[DMEM_ADDR_WIDTH+1:2]];
            end
            OP_STORE: begin
                cat = T_MEM;
                exp_st = 1'b1;
                exp_st_addr = a + {{20{m_ins[31]}}, m_ins[31:25], m_ins[11:7]};
                exp_st_data = b;
            end
            OP_BRANCH: begin
                exp_taken = branch_model(f3, a, b);
                if (exp_taken) exp_next = m_pc + {{20{m_ins[31]}}, m_ins[7], m_ins[30:25],
                                                  m_ins[11:8], 1'b0};
            end
            OP_JAL, OP_JALR: begin
                exp_writes = 1'b1;
                exp_val    = m_pc + 4;
                exp_taken  = 1'b1;
                if (opc == OP_JAL) exp_next = m_pc + {{12{m_ins[31]}}, m_ins[19:12], m_ins[20],
                                                      m_ins[30:21], 1'b0};
                else               exp_next = (a + imm_i) & ~32'h1;
            end
            OP_LUI, OP_AUIPC: begin
                cat = T_UPPER;
                exp_writes = 1'b1;
                exp_val = {m_ins[31:12], 12'b0} + ((opc == OP_AUIPC) ? m_pc : 32'h0);
            end
            default: ;
        endcase
        exp_we = exp_writes && (m_rd != 5'd0);
    endtask

    task automatic commit();
        if (exp_we) m_regs[m_rd] = exp_val;
        if (exp_st) m_mem[exp_st_addr[DMEM_ADDR_WIDTH+1:2]] = exp_st_data;
        m_pc = exp_next;
    endtask

    task automatic check_value(input int t, input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks[t]++;
        assert (got === exp) else begin
            $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            errs[t]++;
        end
    endtask

    task automatic check_quiet_outputs();
        check_value(T_RESET, "imem_addr", 32'(imem_addr), 32'h0);
        check_value(T_RESET, "rd_we", 32'(rd_we), 32'h0);
        check_value(T_RESET, "st_en", 32'(st_en), 32'h0);
        check_value(T_RESET, "pc_taken", 32'(pc_taken), 32'h0);
    endtask

    task automatic report_test(input int t);
        $display("Test %-6s %0d checks, %0d errors", names[t], checks[t], errs[t]);
        total_checks += checks[t];
        total_errs   += errs[t];
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        arst_n       = 1'b0;
        rng_state    = 32'h208d;
        m_pc         = '0;
        total_checks = 0;
        total_errs   = 0;
        done         = 1'b0;
        cycle        = 0;
        for (int i = 0; i < 32; i++) m_regs[i] = '0;
        gen_program();
        repeat (3) begin
            @(posedge sysclk);
            #(STIM_DELAY);
            check_quiet_outputs();
        end
        arst_n = 1'b1;
        while (!done) begin
            @(negedge sysclk);                      // Outputs are settled mid-cycle
            predict();
            if (cycle == 0) begin
                check_quiet_outputs();
                report_test(T_RESET);
            end
            rd_cat = (exp_writes && m_rd == 5'd0) ? T_X0 : cat;
            check_value(T_FLOW, "imem_addr", 32'(imem_addr), m_pc);
            check_value(T_FLOW, "pc_taken", 32'(pc_taken), 32'(exp_taken));
            check_value(rd_cat, "rd_we", 32'(rd_we), 32'(exp_we));
            if (exp_we) begin
                check_value(cat, "rd_addr", 32'(rd_addr), 32'(m_rd));
                check_value(cat, "rd_data", rd_data, exp_val);
            end
            check_value(cat, "st_en", 32'(st_en), 32'(exp_st));
            if (exp_st) begin
                check_value(T_MEM, "st_addr", st_addr, exp_st_addr);
                check_value(T_MEM, "st_data", st_data, exp_st_data);
            end
            if (m_pc == 32'(4 * (N_INSTR - 1))) done = 1'b1;
            commit();
            cycle++;
        end
        @(posedge sysclk);
        #(STIM_DELAY);
        checks[T_BIND]++;
        assert (UUT.bound_checks.fail_count == 0) else begin
            $display("Bound assertions failed %0d times", UUT.bound_checks.fail_count);
            errs[T_BIND]++;
        end
        for (int t = T_ALU; t < NTESTS; t++) report_test(t);
        $display("Summary: %0d cycles, %0d checks, %0d errors", cycle, total_checks, total_errs);
        if (total_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
hw/rv_pkg.sv
hw/alu.sv
hw/control_unit.sv
hw/immediate_generator.sv
hw/register_file.sv
hw/pc_counter.sv
hw/data_memory.sv
hw/cpu.sv
dv/cpu_checker.sv
dv/tb_cpu.sv

// ==== hw/alu.sv ====
////////////////////////////////////////////////////////////
// Combinational ALU with a separate branch comparator
// Shift amounts come from the low 5 bits of operand B
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  logic [XLEN-1:0] op_a,
    input  logic [XLEN-1:0] op_b,
    input  alu_op_e         alu_op,
    input  logic [XLEN-1:0] cmp_a,
    input  logic [XLEN-1:0] cmp_b,
    input  cmp_op_e         cmp_op,
    output logic [XLEN-1:0] result,
    output logic            cmp_true
);

    logic [4:0] shamt;
    logic       op_lt;
    logic       op_ltu;
    logic       cmp_eq;
    logic       cmp_lt;
    logic       cmp_ltu;

    assign shamt  = op_b[4:0];
    assign op_lt  = $signed(op_a) < $signed(op_b);
    assign op_ltu = op_a < op_b;

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_SLL:    result = op_a << shamt;
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, op_lt};
            ALU_SLTU:   result = {{(XLEN-1){1'b0}}, op_ltu};
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SRL:    result = op_a >> shamt;
            ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    // Branch comparison works on the register values, not on the ALU operands
    assign cmp_eq  = cmp_a == cmp_b;
    assign cmp_lt  = $signed(cmp_a) < $signed(cmp_b);
    assign cmp_ltu = cmp_a < cmp_b;

    always_comb begin
        case (cmp_op)
            CMP_EQ:  cmp_true = cmp_eq;
            CMP_NE:  cmp_true = !cmp_eq;
            CMP_LT:  cmp_true = cmp_lt;
            CMP_GE:  cmp_true = !cmp_lt;
            CMP_LTU: cmp_true = cmp_ltu;
            CMP_GEU: cmp_true = !cmp_ltu;
            default: cmp_true = 1'b0;       // funct3 010 and 011 never branch
        endcase
    end

endmodule

// ==== hw/control_unit.sv ====
////////////////////////////////////////////////////////////
// Instruction decode for the RV32I subset of the core
// Unknown opcodes, the all-zero word included, act as NOPs
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module control_unit import rv_pkg::*; (
    input  logic [31:0] instr,
    output logic [4:0]  rs1_addr,
    output logic [4:0]  rs2_addr,
    output logic [4:0]  rd_addr,
    output alu_op_e     alu_op,
    output cmp_op_e     cmp_op,
    output logic        a_pc_sel,
    output logic        b_imm_sel,
    output logic        rf_we,
    output logic        mem_we,
    output logic        branch,
    output logic        jump,
    output logic        jalr,
    output wb_sel_e     wb_sel
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;            // Bit 30 selects SUB and SRA
    logic       rf_en;

    // Maps funct3 to an ALU operation. SUB exists only in register form
    function automatic alu_op_e decode_alu(input logic [2:0] f3, input logic sub_ok,
                                           input logic alt_bit);
        alu_op_e op;
        case (f3)
            3'b000:  op = (sub_ok && alt_bit) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt_bit ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode   = opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign alt      = instr[30];
    assign rd_addr  = instr[11:7];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign cmp_op   = cmp_op_e'(funct3);

    always_comb begin
        alu_op    = ALU_ADD;
        a_pc_sel  = 1'b0;
        b_imm_sel = 1'b0;
        rf_en     = 1'b0;
        mem_we    = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        jalr      = 1'b0;
        wb_sel    = WB_ALU;
        case (opcode)
            OPC_OP: begin
                rf_en  = 1'b1;
                alu_op = decode_alu(funct3, 1'b1, alt);
            end
            OPC_OP_IMM: begin
                rf_en     = 1'b1;
                b_imm_sel = 1'b1;
                alu_op    = decode_alu(funct3, 1'b0, alt);
            end
            OPC_LOAD: begin
                rf_en     = 1'b1;
                b_imm_sel = 1'b1;
                wb_sel    = WB_MEM;
            end
            OPC_STORE: begin
                b_imm_sel = 1'b1;
                mem_we    = 1'b1;
            end
            OPC_BRANCH: begin
                a_pc_sel  = 1'b1;       // Target is PC plus offset
                b_imm_sel = 1'b1;
                branch    = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                rf_en     = 1'b1;
                a_pc_sel  = opcode == OPC_JAL;
                b_imm_sel = 1'b1;
                jump      = 1'b1;
                jalr      = opcode == OPC_JALR;
                wb_sel    = WB_PC4;
            end
            OPC_LUI: begin
                rf_en     = 1'b1;
                b_imm_sel = 1'b1;
                alu_op    = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                rf_en     = 1'b1;
                a_pc_sel  = 1'b1;
                b_imm_sel = 1'b1;
            end
            default: ;
        endcase
    end

    // x0 is never written
    assign rf_we = rf_en && (rd_addr != 5'd0);

endmodule

// ==== hw/cpu.sv ====
////////////////////////////////////////////////////////////
// Single-cycle RV32I core, one instruction per sysclk cycle
// Program memory is external with combinational read.
// Loads and stores move whole aligned words only
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cpu import rv_pkg::*; #(
    parameter int PC_WIDTH        = 16,
    parameter int DMEM_ADDR_WIDTH = 10
) (
    input  logic                sysclk,
    input  logic                arst_n,
    input  logic [31:0]         imem_rdata,
    output logic [PC_WIDTH-1:0] imem_addr,
    output logic                rd_we,
    output logic [4:0]          rd_addr,
    output logic [XLEN-1:0]     rd_data,
    output logic                st_en,
    output logic [XLEN-1:0]     st_addr,
    output logic [XLEN-1:0]     st_data,
    output logic                pc_taken
);

    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    alu_op_e         alu_op;
    cmp_op_e         cmp_op;
    wb_sel_e         wb_sel;
    logic            a_pc_sel;
    logic            b_imm_sel;
    logic            branch;
    logic            jump;
    logic            jalr;
    logic            cmp_true;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] pc_plus4;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////
    control_unit control_unit_cpu (
        .instr(imem_rdata), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
        .alu_op(alu_op), .cmp_op(cmp_op), .a_pc_sel(a_pc_sel), .b_imm_sel(b_imm_sel),
        .rf_we(rd_we), .mem_we(st_en), .branch(branch), .jump(jump), .jalr(jalr),
        .wb_sel(wb_sel)
    );

    immediate_generator immediate_generator_cpu (.instr(imem_rdata), .imm(imm));

    register_file register_file_cpu (
        .sysclk(sysclk), .arst_n(arst_n), .we(rd_we), .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr), .rd_addr(rd_addr), .rd_data(rd_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    ////////////////////////////////////////////////////////////
    // Execute and memory
    ////////////////////////////////////////////////////////////
    assign op_a = a_pc_sel ? {{(XLEN-PC_WIDTH){1'b0}}, imem_addr} : rs1_data;
    assign op_b = b_imm_sel ? imm : rs2_data;

    alu alu_cpu (
        .op_a(op_a), .op_b(op_b), .alu_op(alu_op), .cmp_a(rs1_data), .cmp_b(rs2_data),
        .cmp_op(cmp_op), .result(alu_result), .cmp_true(cmp_true)
    );

    data_memory #(.DMEM_ADDR_WIDTH(DMEM_ADDR_WIDTH)) data_memory_cpu (
        .sysclk(sysclk), .we(st_en), .addr(alu_result[DMEM_ADDR_WIDTH+1:2]),
        .wdata(rs2_data), .rdata(load_data)
    );

    assign st_addr = alu_result;
    assign st_data = rs2_data;

    always_comb begin
        case (wb_sel)
            WB_MEM:  rd_data = load_data;
            WB_PC4:  rd_data = pc_plus4;
            default: rd_data = alu_result;
        endcase
    end

    // The ALU result doubles as the branch and jump target
    pc_counter #(.PC_WIDTH(PC_WIDTH)) pc_counter_cpu (
        .sysclk(sysclk), .arst_n(arst_n), .branch(branch), .jump(jump), .jalr(jalr),
        .cmp_true(cmp_true), .target(alu_result), .pc(imem_addr), .pc_plus4(pc_plus4),
        .taken(pc_taken)
    );

endmodule

// ==== hw/data_memory.sv ====
////////////////////////////////////////////////////////////
// Word-addressed data RAM, whole-word access only
// Combinational read, write at the rising edge
// Contents are undefined until written
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module data_memory import rv_pkg::*; #(
    parameter int DMEM_ADDR_WIDTH = 10
) (
    input  logic                       sysclk,
    input  logic                       we,
    input  logic [DMEM_ADDR_WIDTH-1:0] addr,
    input  logic [XLEN-1:0]            wdata,
    output logic [XLEN-1:0]            rdata
);

    localparam int DEPTH = 1 << DMEM_ADDR_WIDTH;

    logic [XLEN-1:0] mem [0:DEPTH-1];

    always_ff @(posedge sysclk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Load data is ready within the same cycle as the address
    assign rdata = mem[addr];

endmodule

// ==== hw/immediate_generator.sv ====
////////////////////////////////////////////////////////////
// Sign-extended immediate for the I, S, B, U and J formats
// Opcodes without an immediate give zero
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module immediate_generator import rv_pkg::*; (
    input  logic [31:0]     instr,
    output logic [XLEN-1:0] imm
);

    opcode_e opcode;

    assign opcode = opcode_e'(instr[6:0]);

    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_LOAD, OPC_JALR:
                imm = {{20{instr[31]}}, instr[31:20]};
            OPC_STORE:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OPC_BRANCH:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:
                imm = {instr[31:12], 12'b0};
            OPC_JAL:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

// ==== hw/pc_counter.sv ====
////////////////////////////////////////////////////////////
// Program counter with next-PC selection
// Only the low PC_WIDTH bits of a jump target are kept
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pc_counter import rv_pkg::*; #(
    parameter int PC_WIDTH = 16
) (
    input  logic                sysclk,
    input  logic                arst_n,
    input  logic                branch,
    input  logic                jump,
    input  logic                jalr,
    input  logic                cmp_true,
    input  logic [XLEN-1:0]     target,
    output logic [PC_WIDTH-1:0] pc,
    output logic [XLEN-1:0]     pc_plus4,
    output logic                taken
);

    logic [PC_WIDTH-1:0] target_pc;
    logic [PC_WIDTH-1:0] next_pc;

    // JALR drops bit 0 of the computed address
    assign target_pc = {target[PC_WIDTH-1:1], target[0] & ~jalr};

    assign pc_plus4 = {{(XLEN-PC_WIDTH){1'b0}}, pc} + XLEN'(4);
    assign taken    = jump || (branch && cmp_true);
    assign next_pc  = taken ? target_pc : pc_plus4[PC_WIDTH-1:0];

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

// ==== hw/register_file.sv ====
////////////////////////////////////////////////////////////
// 32 x XLEN register file, two combinational read ports
// A read in the cycle of a write to the same register
// returns the old value
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module register_file import rv_pkg::*; (
    input  logic            sysclk,
    input  logic            arst_n,
    input  logic            we,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    input  logic [4:0]      rd_addr,
    input  logic [XLEN-1:0] rd_data,
    output logic [XLEN-1:0] rs1_data,
    output logic [XLEN-1:0] rs2_data
);

    logic [XLEN-1:0] regs [1:31];       // x0 has no storage

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_addr != 5'd0)) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== hw/rv_pkg.sv ====
////////////////////////////////////////////////////////////
// Definitions shared by the RV32I core blocks
// Only the opcodes of the supported subset are listed. Any
// other major opcode is decoded as no operation
////////////////////////////////////////////////////////////

package rv_pkg;

    // Data path width, fixed by the instruction set
    localparam int XLEN = 32;

    ////////////////////////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////////////////////////
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10       // Forwards operand B, used by LUI
    } alu_op_e;

    // Branch conditions, encoded exactly as funct3 of the branch opcode
    typedef enum logic [2:0] {
        CMP_EQ  = 3'b000,
        CMP_NE  = 3'b001,
        CMP_LT  = 3'b100,
        CMP_GE  = 3'b101,
        CMP_LTU = 3'b110,
        CMP_GEU = 3'b111
    } cmp_op_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2            // Link address for JAL and JALR
    } wb_sel_e;

endpackage
